// ==== source/cache_pkg.sv ====
package cache_pkg;

    localparam int MAT_DIM     = 4;
    localparam int MAT_WORDS   = 16;
    localparam int OUT_CREDITS = 4; // Credit limit toward the array
    localparam int DDR_CREDITS = 2;

    typedef logic [15:0]                        word_t;
    typedef logic [27:0]                        ddr_addr_t;
    typedef logic [$clog2(MAT_WORDS)-1:0]       idx_t;
    typedef logic [$clog2(MAT_DIM)-1:0]         rc_t;
    typedef logic [2:0]                         cmd_t;
    typedef logic [$clog2(OUT_CREDITS+1)-1:0]   out_cred_t;
    typedef logic [$clog2(DDR_CREDITS+1)-1:0]   ddr_cred_t;

    localparam cmd_t CMD_NONE      = 3'd0;
    localparam cmd_t CMD_ROW_LOAD  = 3'd1;
    localparam cmd_t CMD_ROW_STORE = 3'd2;
    localparam cmd_t CMD_COL_LOAD  = 3'd3;
    localparam cmd_t CMD_COL_STORE = 3'd4;
    localparam cmd_t CMD_ADDR_LOAD = 3'd5;

    typedef enum logic [2:0] {
        OP_ROW_LOAD,
        OP_ROW_STORE,
        OP_COL_LOAD,
        OP_COL_STORE,
        OP_ADDR_LOAD,
        OP_DDR_ONLY
    } cache_op_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_SEND_ROW,
        S_SEND_COL,
        S_GET_ROW,
        S_GET_COL,
        S_SEND_ADDR,
        S_DDR_WRITE,
        S_DDR_END
    } seq_state_e;

endpackage

// ==== source/cache_if.sv ====
`timescale 1ns/100ps

// Decoded operation handed from decode to execute
interface cache_op_if import cache_pkg::*; ();
    logic       op_valid;
    cache_op_e  op;
    logic       ddr_en;
    ddr_addr_t  ddr_base;
    logic       busy;

    modport decode (output op_valid, op, ddr_en, ddr_base, input busy);
    modport seq    (input op_valid, op, ddr_en, ddr_base, output busy);
endinterface

// Per-cycle stream requests from execute to the result stage
interface cache_res_if import cache_pkg::*; ();
    logic       out_req;
    logic       ddr_req;
    ddr_addr_t  ddr_addr;
    logic       sel_addr_word;
    word_t      addr_word;
    logic       done_req;
    logic       out_can;
    logic       ddr_can;

    modport seq (
        output out_req, ddr_req, ddr_addr, sel_addr_word, addr_word, done_req,
        input  out_can, ddr_can
    );
    modport result (
        input  out_req, ddr_req, ddr_addr, sel_addr_word, addr_word, done_req,
        output out_can, ddr_can
    );
endinterface

// ==== source/cache_cmd_decode.sv ====
`timescale 1ns/100ps

module cache_cmd_decode import cache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cmd_valid,
    input  cmd_t        cmd,
    input  logic        store_ddr_en,
    input  ddr_addr_t   ddr_base,
    output logic        cmd_ready,
    output logic        cmd_err_req,
    cache_op_if.decode  op
);

    logic accept;
    logic legal;

    // Loads with the DDR flag skip their own transfer and only write DDR
    function automatic cache_op_e map_op(input cmd_t code, input logic ddr_flag);
        cache_op_e mapped;
        if (ddr_flag && code != CMD_ROW_STORE && code != CMD_COL_STORE) begin
            mapped = OP_DDR_ONLY;
        end else begin
            case (code)
                CMD_ROW_LOAD:  mapped = OP_ROW_LOAD;
                CMD_ROW_STORE: mapped = OP_ROW_STORE;
                CMD_COL_LOAD:  mapped = OP_COL_LOAD;
                CMD_COL_STORE: mapped = OP_COL_STORE;
                CMD_ADDR_LOAD: mapped = OP_ADDR_LOAD;
                default:       mapped = OP_DDR_ONLY;
            endcase
        end
        return mapped;
    endfunction

    assign legal = (cmd >= CMD_ROW_LOAD && cmd <= CMD_ADDR_LOAD) ||
                   (cmd == CMD_NONE && store_ddr_en);
    assign accept = cmd_valid && cmd_ready;

    // Pending covers the cycle between acceptance and busy rising
    assign cmd_ready = !(op.op_valid || cmd_err_req || op.busy);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            op.op_valid <= 1'b0;
            cmd_err_req <= 1'b0;
        end else begin
            op.op_valid <= accept && legal;
            cmd_err_req <= accept && !legal;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op.op       <= map_op(cmd, store_ddr_en);
            op.ddr_en   <= store_ddr_en;
            op.ddr_base <= ddr_base; // Held until the next accepted command
        end
    end

endmodule

// ==== source/cache_seq.sv ====
`timescale 1ns/100ps

module cache_seq import cache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    cache_op_if.seq     op,
    cache_res_if.seq    res,
    input  logic        in_valid,
    input  word_t       in_data,
    output logic        wr_en,
    output idx_t        wr_idx,
    output word_t       wr_data,
    output idx_t        rd_idx
);

    seq_state_e state;
    seq_state_e state_next;
    rc_t        row_q;
    rc_t        col_q;
    idx_t       word_q;
    idx_t       cur_idx;
    logic       step;
    logic       last;
    logic       col_major;
    logic [1:0] tail_q;

    assign cur_idx   = {row_q, col_q};
    assign col_major = (state == S_SEND_COL) || (state == S_GET_COL);
    assign last      = (state == S_SEND_ADDR) ? (word_q == idx_t'(1)) :
                                                (word_q == idx_t'(MAT_WORDS - 1));

    // Tail keeps busy up until done has left the result stage
    assign op.busy = (state != S_IDLE) || (tail_q != 2'b00);

    assign rd_idx  = cur_idx;
    assign wr_idx  = cur_idx;
    assign wr_data = in_data;

    always_comb begin
        state_next        = state;
        step              = 1'b0;
        wr_en             = 1'b0;
        res.out_req       = 1'b0;
        res.ddr_req       = 1'b0;
        res.done_req      = 1'b0;
        res.sel_addr_word = (state == S_SEND_ADDR);
        res.addr_word     = word_q[0] ? op.ddr_base[15:0] : {4'd0, op.ddr_base[27:16]};
        res.ddr_addr      = op.ddr_base + ddr_addr_t'(cur_idx);
        case (state)
            S_IDLE: begin
                if (op.op_valid) begin
                    case (op.op)
                        OP_ROW_LOAD:  state_next = S_SEND_ROW;
                        OP_ROW_STORE: state_next = S_GET_ROW;
                        OP_COL_LOAD:  state_next = S_SEND_COL;
                        OP_COL_STORE: state_next = S_GET_COL;
                        OP_ADDR_LOAD: state_next = S_SEND_ADDR;
                        default:      state_next = S_DDR_WRITE;
                    endcase
                end
            end
            S_SEND_ROW, S_SEND_COL, S_SEND_ADDR: begin
                res.out_req = res.out_can; // Stall here while the array has no credit
                step        = res.out_can;
                if (step && last) begin
                    state_next = S_DDR_END;
                end
            end
            S_GET_ROW, S_GET_COL: begin
                wr_en = in_valid;
                step  = in_valid;
                if (step && last) begin
                    state_next = op.ddr_en ? S_DDR_WRITE : S_DDR_END;
                end
            end
            S_DDR_WRITE: begin
                res.ddr_req = res.ddr_can;
                step        = res.ddr_can;
                if (step && last) begin
                    state_next = S_DDR_END;
                end
            end
            S_DDR_END: begin
                res.done_req = 1'b1;
                state_next   = S_IDLE;
            end
            default: state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state  <= S_IDLE;
            row_q  <= '0;
            col_q  <= '0;
            word_q <= '0;
            tail_q <= '0;
        end else begin
            state  <= state_next;
            tail_q <= {tail_q[0], res.done_req};
            if (step) begin
                if (last) begin
                    row_q  <= '0;
                    col_q  <= '0;
                    word_q <= '0;
                end else begin
                    word_q <= word_q + 1'b1;
                    if (col_major) begin
                        // Column is the outer loop here
                        row_q <= row_q + 1'b1;
                        if (row_q == rc_t'(MAT_DIM - 1)) begin
                            col_q <= col_q + 1'b1;
                        end
                    end else begin
                        col_q <= col_q + 1'b1;
                        if (col_q == rc_t'(MAT_DIM - 1)) begin
                            row_q <= row_q + 1'b1;
                        end
                    end
                end
            end
        end
    end

endmodule

// ==== source/cache_mem.sv ====
`timescale 1ns/100ps

module cache_mem import cache_pkg::*; (
    input  logic    clk,
    input  logic    wr_en,
    input  idx_t    wr_idx,
    input  word_t   wr_data,
    input  idx_t    rd_idx,
    output word_t   rd_data
);

    word_t mem [MAT_WORDS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
        rd_data <= mem[rd_idx]; // Read is registered on every clock
    end

endmodule

// ==== source/cache_result.sv ====
`timescale 1ns/100ps

module cache_result import cache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    cache_res_if.result res,
    input  word_t       rd_data,
    input  logic        cmd_err_req,
    input  logic        out_credit,
    input  logic        ddr_credit,
    output logic        out_valid,
    output word_t       out_data,
    output logic        ddr_wr_valid,
    output ddr_addr_t   ddr_wr_addr,
    output word_t       ddr_wr_data,
    output logic        done,
    output logic        cmd_err
);

    out_cred_t  out_cnt;
    ddr_cred_t  ddr_cnt;
    logic       out_req_q;
    logic       ddr_req_q;
    logic       done_q;
    logic       sel_q;
    word_t      addr_word_q;
    ddr_addr_t  ddr_addr_q;

    assign res.out_can = (out_cnt != '0);
    assign res.ddr_can = (ddr_cnt != '0);
    assign cmd_err     = cmd_err_req;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out_cnt      <= out_cred_t'(OUT_CREDITS);
            ddr_cnt      <= ddr_cred_t'(DDR_CREDITS);
            out_req_q    <= 1'b0;
            ddr_req_q    <= 1'b0;
            done_q       <= 1'b0;
            out_valid    <= 1'b0;
            ddr_wr_valid <= 1'b0;
            done         <= 1'b0;
        end else begin
            // Credit is spent when the request is made, not when the word leaves
            out_cnt      <= out_cnt - out_cred_t'(res.out_req) + out_cred_t'(out_credit);
            ddr_cnt      <= ddr_cnt - ddr_cred_t'(res.ddr_req) + ddr_cred_t'(ddr_credit);
            out_req_q    <= res.out_req;
            ddr_req_q    <= res.ddr_req;
            done_q       <= res.done_req;
            out_valid    <= out_req_q;
            ddr_wr_valid <= ddr_req_q;
            // The done request trails the last data request through both stages
            done         <= done_q;
        end
    end

    always_ff @(posedge clk) begin
        sel_q       <= res.sel_addr_word;
        addr_word_q <= res.addr_word;
        ddr_addr_q  <= res.ddr_addr;
        if (out_req_q) begin
            out_data <= sel_q ? addr_word_q : rd_data;
        end
        if (ddr_req_q) begin
            ddr_wr_addr <= ddr_addr_q;
            ddr_wr_data <= rd_data;
        end
    end

endmodule

// ==== source/data_cache_top.sv ====
`timescale 1ns/100ps

module data_cache_top import cache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cmd_valid,
    input  cmd_t        cmd,
    input  logic        store_ddr_en,
    input  ddr_addr_t   ddr_base,
    output logic        cmd_ready,
    input  logic        in_valid,
    input  word_t       in_data,
    output logic        out_valid,
    output word_t       out_data,
    input  logic        out_credit,
    output logic        ddr_wr_valid,
    output ddr_addr_t   ddr_wr_addr,
    output word_t       ddr_wr_data,
    input  logic        ddr_credit,
    output logic        done,
    output logic        cmd_err
);

    logic   cmd_err_req;
    logic   wr_en;
    idx_t   wr_idx;
    word_t  wr_data;
    idx_t   rd_idx;
    word_t  rd_data;

    cache_op_if  op_if ();
    cache_res_if res_if ();

    cache_cmd_decode decode_i (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .store_ddr_en (store_ddr_en),
        .ddr_base     (ddr_base),
        .cmd_ready    (cmd_ready),
        .cmd_err_req  (cmd_err_req),
        .op           (op_if.decode)
    );

    cache_seq seq_i (
        .clk      (clk),
        .rst      (rst),
        .op       (op_if.seq),
        .res      (res_if.seq),
        .in_valid (in_valid),
        .in_data  (in_data),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data),
        .rd_idx   (rd_idx)
    );

    cache_mem mem_i (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .rd_idx  (rd_idx),
        .rd_data (rd_data)
    );

    cache_result result_i (
        .clk          (clk),
        .rst          (rst),
        .res          (res_if.result),
        .rd_data      (rd_data),
        .cmd_err_req  (cmd_err_req),
        .out_credit   (out_credit),
        .ddr_credit   (ddr_credit),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .ddr_wr_valid (ddr_wr_valid),
        .ddr_wr_addr  (ddr_wr_addr),
        .ddr_wr_data  (ddr_wr_data),
        .done         (done),
        .cmd_err      (cmd_err)
    );

endmodule

// ==== tb/data_cache_assert.sv ====
`timescale 1ns/100ps

module data_cache_assert import cache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cmd_ready,
    input  out_cred_t   out_cnt,
    input  ddr_cred_t   ddr_cnt,
    input  logic        done,
    input  logic        cmd_err
);

    // A new command is taken only once the previous one has ended with done or cmd_err
    ready_after_end: assert property (@(posedge clk) disable iff (!rst)
        $rose(cmd_ready) |-> $past(done || cmd_err))
        else $error("cmd_ready came back without a done or cmd_err the cycle before");

    out_credit_limit: assert property (@(posedge clk) disable iff (!rst) out_cnt <= OUT_CREDITS)
        else $error("Array credit counter went above its limit");

    ddr_credit_limit: assert property (@(posedge clk) disable iff (!rst) ddr_cnt <= DDR_CREDITS)
        else $error("DDR credit counter went above its limit");

    done_err_apart: assert property (@(posedge clk) disable iff (!rst) !(done && cmd_err))
        else $error("done and cmd_err were high in the same cycle");

endmodule

bind data_cache_top data_cache_assert assert_i (
    .clk       (clk),
    .rst       (rst),
    .cmd_ready (cmd_ready),
    .out_cnt   (result_i.out_cnt),
    .ddr_cnt   (result_i.ddr_cnt),
    .done      (done),
    .cmd_err   (cmd_err)
);

// ==== tb/data_cache_tb.sv ====
`timescale 1ns/100ps

module data_cache_tb import cache_pkg::*; ();

    localparam int CMD_BUDGET      = 250; // Cycles allowed for one command
    localparam int WATCHDOG_CYCLES = 16 * CMD_BUDGET;

    logic       clk = 1'b0;
    logic       rst;
    logic       cmd_valid;
    cmd_t       cmd;
    logic       store_ddr_en;
    ddr_addr_t  ddr_base;
    logic       cmd_ready;
    logic       in_valid;
    word_t      in_data;
    logic       out_valid;
    word_t      out_data;
    logic       out_credit;
    logic       ddr_wr_valid;
    ddr_addr_t  ddr_wr_addr;
    word_t      ddr_wr_data;
    logic       ddr_credit;
    logic       done;
    logic       cmd_err;

    word_t      model [MAT_WORDS];
    word_t      in_words [MAT_WORDS];
    word_t      out_q [$];
    word_t      expect_q [$];
    ddr_addr_t  ddr_addr_q [$];
    word_t      ddr_data_q [$];
    logic       hold_out = 1'b0;
    int         errors = 0;
    int         done_cnt = 0;
    int         err_cnt = 0;
    int         out_recv = 0;
    int         out_ret = 0;
    int         ddr_recv = 0;
    int         ddr_ret = 0;

    data_cache_top data_cache_top_i (.*);

    always #2 clk = ~clk;

    // Consumers collect words where the registered outputs are stable
    always @(negedge clk) begin
        if (out_valid) begin
            out_q.push_back(out_data);
            out_recv++;
            if (out_recv - out_ret > OUT_CREDITS) begin
                $display("More words reached the array than its credits allow");
                errors++;
            end
        end
        if (ddr_wr_valid) begin
            ddr_addr_q.push_back(ddr_wr_addr);
            ddr_data_q.push_back(ddr_wr_data);
            ddr_recv++;
            if (ddr_recv - ddr_ret > DDR_CREDITS) begin
                $display("More DDR writes arrived than DDR credits allow");
                errors++;
            end
        end
        if (done) done_cnt++;
        if (cmd_err) err_cnt++;
    end

    initial begin : out_credit_loop
        int gap;
        gap = 0;
        out_credit = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            out_credit = 1'b0;
            if (out_recv > out_ret && !hold_out) begin
                if (gap == 0) begin
                    out_credit = 1'b1;
                    out_ret++;
                    gap = $urandom_range(3);
                end else begin
                    gap--;
                end
            end
        end
    end

    initial begin : ddr_credit_loop
        int gap;
        gap = 0;
        ddr_credit = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            ddr_credit = 1'b0;
            if (ddr_recv > ddr_ret) begin
                if (gap == 0) begin
                    ddr_credit = 1'b1;
                    ddr_ret++;
                    gap = $urandom_range(3);
                end else begin
                    gap--;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, a command never finished", WATCHDOG_CYCLES);
        $display("Errors: %0d", errors);
        $display("Verification failed");
        $finish;
    end

    // Position of the k-th streamed word in the matrix
    function automatic idx_t scan_idx(input int k, input logic col);
        return col ? idx_t'((k % MAT_DIM) * MAT_DIM + k / MAT_DIM) : idx_t'(k);
    endfunction

    task automatic start_capture();
        out_q.delete();
        expect_q.delete();
        ddr_addr_q.delete();
        ddr_data_q.delete();
    endtask

    task automatic send_command(input cmd_t code, input logic flag, input ddr_addr_t base);
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        cmd_valid    = 1'b1;
        cmd          = code;
        store_ddr_en = flag;
        ddr_base     = base;
        @(negedge clk);
        while (!cmd_ready && waited < CMD_BUDGET) begin
            waited++;
            @(negedge clk);
        end
        if (!cmd_ready) begin
            $display("Command %0d was never accepted, cmd_ready stayed low", code);
            errors++;
        end
        @(posedge clk); // Accepted on this edge
        #1;
        cmd_valid = 1'b0;
    endtask

    // Execute enters its receive state one edge after acceptance
    task automatic stream_words();
        int k;
        k = 0;
        while (k < MAT_WORDS) begin
            @(posedge clk);
            #1;
            if ($urandom_range(3) == 0) begin
                in_valid = 1'b0;
            end else begin
                in_valid = 1'b1;
                in_data  = in_words[k];
                k++;
            end
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic wait_for_done(input string name);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!done && waited < CMD_BUDGET) begin
            waited++;
            @(negedge clk);
        end
        if (!done) begin
            $display("%s: done never came", name);
            errors++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic compare_out(input string name);
        int i;
        if (out_q.size() != expect_q.size()) begin
            $display("ERR %s: expected %0d words, actual %0d words", name, expect_q.size(),
                     out_q.size());
            errors++;
        end else begin
            for (i = 0; i < expect_q.size(); i++) begin
                if (out_q[i] != expect_q[i]) begin
                    $display("ERR %s word %0d: expected %h, actual %h", name, i, expect_q[i],
                             out_q[i]);
                    errors++;
                end
            end
        end
    endtask

    task automatic compare_ddr(input string name, input ddr_addr_t base, input int count);
        int i;
        if (ddr_addr_q.size() != count) begin
            $display("ERR %s: expected %0d DDR writes, actual %0d", name, count,
                     ddr_addr_q.size());
            errors++;
        end else begin
            for (i = 0; i < count; i++) begin
                if (ddr_addr_q[i] != base + ddr_addr_t'(i) || ddr_data_q[i] != model[i]) begin
                    $display("ERR %s DDR write %0d: expected %h at %h, actual %h at %h", name, i,
                             model[i], base + ddr_addr_t'(i), ddr_data_q[i], ddr_addr_q[i]);
                    errors++;
                end
            end
        end
    endtask

    task automatic run_store(input string name, input cmd_t code, input logic flag,
                             input ddr_addr_t base, input logic col);
        int k;
        for (k = 0; k < MAT_WORDS; k++) begin
            in_words[k] = word_t'($urandom);
            model[scan_idx(k, col)] = in_words[k];
        end
        start_capture();
        send_command(code, flag, base);
        stream_words();
        wait_for_done(name);
        compare_out(name); // A store sends nothing to the array
        compare_ddr(name, base, flag ? MAT_WORDS : 0);
    endtask

    task automatic run_load(input string name, input cmd_t code, input logic col);
        int k;
        start_capture();
        for (k = 0; k < MAT_WORDS; k++) expect_q.push_back(model[scan_idx(k, col)]);
        send_command(code, 1'b0, '0);
        wait_for_done(name);
        compare_out(name);
        compare_ddr(name, '0, 0);
    endtask

    task automatic run_ddr_only(input string name, input cmd_t code, input ddr_addr_t base);
        start_capture();
        send_command(code, 1'b1, base);
        wait_for_done(name);
        compare_out(name);
        compare_ddr(name, base, MAT_WORDS);
    endtask

    task automatic run_addr_load(input string name);
        ddr_addr_t base;
        base = ddr_addr_t'($urandom);
        start_capture();
        expect_q.push_back({4'd0, base[27:16]});
        expect_q.push_back(base[15:0]);
        send_command(CMD_ADDR_LOAD, 1'b0, base);
        wait_for_done(name);
        compare_out(name);
    endtask

    task automatic back_pressure();
        int waited;
        int k;
        waited = 0;
        while (out_recv != out_ret && waited < CMD_BUDGET) begin
            @(posedge clk);
            waited++;
        end
        #1;
        hold_out = 1'b1;
        start_capture();
        for (k = 0; k < MAT_WORDS; k++) expect_q.push_back(model[k]);
        send_command(CMD_ROW_LOAD, 1'b0, '0);
        repeat (8 * OUT_CREDITS) @(posedge clk);
        #1;
        if (out_q.size() != OUT_CREDITS) begin
            $display("ERR back pressure: expected %0d words, actual %0d words", OUT_CREDITS,
                     out_q.size());
            errors++;
        end
        hold_out = 1'b0;
        wait_for_done("back pressure");
        compare_out("back pressure");
    endtask

    task automatic illegal_cmd(input cmd_t code, input logic flag);
        int err_before;
        int done_before;
        err_before  = err_cnt;
        done_before = done_cnt;
        start_capture();
        send_command(code, flag, '0);
        repeat (4) @(posedge clk); // cmd_err comes one cycle after acceptance
        #1;
        if (err_cnt != err_before + 1) begin
            $display("Illegal command %0d did not give one cmd_err pulse", code);
            errors++;
        end
        if (done_cnt != done_before || out_q.size() != 0 || ddr_addr_q.size() != 0) begin
            $display("Illegal command %0d caused a transfer or a done", code);
            errors++;
        end
        if (!cmd_ready) begin
            $display("cmd_ready did not return after illegal command %0d", code);
            errors++;
        end
    endtask

    initial begin
        void'($urandom(15));
        rst          = 1'b0;
        cmd_valid    = 1'b0;
        cmd          = CMD_NONE;
        store_ddr_en = 1'b0;
        ddr_base     = '0;
        in_valid     = 1'b0;
        in_data      = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b1;
        @(negedge clk);
        if (out_valid || ddr_wr_valid || done || cmd_err || !cmd_ready) begin
            $display("Outputs are not in their reset state after reset");
            errors++;
        end

        run_store("row store", CMD_ROW_STORE, 1'b0, '0, 1'b0);
        run_load("row load", CMD_ROW_LOAD, 1'b0);

        run_store("column store", CMD_COL_STORE, 1'b0, '0, 1'b1);
        run_load("row load after column store", CMD_ROW_LOAD, 1'b0);
        run_load("column load", CMD_COL_LOAD, 1'b1);

        run_addr_load("address load");

        run_store("row store to DDR", CMD_ROW_STORE, 1'b1, ddr_addr_t'($urandom), 1'b0);
        run_ddr_only("command 0 to DDR", CMD_NONE, ddr_addr_t'($urandom));
        run_ddr_only("row load to DDR", CMD_ROW_LOAD, ddr_addr_t'($urandom));

        back_pressure();

        illegal_cmd(3'd6, 1'b0);
        illegal_cmd(3'd7, 1'b1);
        illegal_cmd(CMD_NONE, 1'b0);
        run_addr_load("address load after illegal commands");

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
source/cache_pkg.sv
source/cache_if.sv
source/cache_cmd_decode.sv
source/cache_seq.sv
source/cache_mem.sv
source/cache_result.sv
source/data_cache_top.sv
tb/data_cache_assert.sv
tb/data_cache_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module data_cache_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vdata_cache_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1
